/* common/board_pkg.sv */
package board_pkg;

    // Board dimensions
    localparam int PLAYERS     = 4;
    localparam int BOARD_JOY_W = 16;
    localparam int GAME_JOY_W  = 10;
    localparam int STATUS_W    = 32;
    localparam int ASPECT_W    = 12;
    localparam int FX_W        = 2;
    localparam int CORE_MOD_W  = 7;
    localparam int GAME_LED_W  = 2;

    // Timing
    localparam int RST_HOLD    = 16;
    localparam int RST_CNT_W   = $clog2(RST_HOLD + 1);
    localparam int COIN_CYCLES = 8;
    localparam int COIN_CNT_W  = $clog2(COIN_CYCLES);
    localparam int LED_BLINK_W = 5;

    localparam logic GAME_INPUTS_ACTIVE_LOW = 1'b1;

    // Joystick bit positions
    localparam int JOY_RIGHT   = 0;
    localparam int JOY_LEFT    = 1;
    localparam int JOY_DOWN    = 2;
    localparam int JOY_UP      = 3;
    localparam int JOY_BTN     = 4;
    localparam int JOY_COIN    = 10;
    localparam int JOY_START   = 11;
    localparam int JOY_SERVICE = 12;

    // Status word fields
    localparam int ST_ROTATE   = 1;
    localparam int ST_FLIP     = 2;
    localparam int ST_TEST     = 3;
    localparam int ST_PAUSE    = 4;
    localparam int ST_NO_FM    = 5;
    localparam int ST_NO_PSG   = 6;
    localparam int ST_FX       = 7;
    localparam int ST_ROT_CTRL = 9;

    // core_mod bit 0 marks a vertical game
    localparam int CM_VERTICAL = 0;

    typedef logic [BOARD_JOY_W-1:0] board_joy_t;
    typedef logic [GAME_JOY_W-1:0]  game_joy_t;
    typedef logic [STATUS_W-1:0]    status_t;
    typedef logic [ASPECT_W-1:0]    aspect_t;
    typedef logic [FX_W-1:0]        fx_t;

    localparam aspect_t ASPECT_H_X = 12'd4;
    localparam aspect_t ASPECT_H_Y = 12'd3;

    typedef enum logic [1:0] {
        LED_GAME,
        LED_OSD,
        LED_BLINK
    } led_state_t;

endpackage

/* common/player_if.sv */
// One player's mapped controls, already at game polarity
interface player_if
    import board_pkg::*;
();
    game_joy_t joy;
    logic      coin;
    logic      start;
    logic      service;

    modport channel (
        output joy,
        output coin,
        output start,
        output service
    );

    modport collect (
        input joy,
        input coin,
        input start,
        input service
    );
endinterface

/* reset/board_reset.sv */
module board_reset
    import board_pkg::*;
(
    input  logic clk_sys,
    input  logic rst_n,
    input  logic pll_locked,
    input  logic rst_req,
    input  logic downloading,
    input  logic soft_rst,
    input  logic dip_flip,
    output logic sys_rst_n,
    output logic game_rst_n
);

    logic [1:0]           rst_sync;
    logic [RST_CNT_W-1:0] hold_cnt;
    logic                 flip_prev;
    logic                 dl_prev;
    logic                 flip_chg;
    logic                 dl_fall;
    logic                 rst_cause;

    // Two stage synchronizer, released only once the PLL is locked
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            rst_sync <= '0;
        end else begin
            rst_sync <= {rst_sync[0], pll_locked};
        end
    end

    assign sys_rst_n = rst_sync[1];

    assign flip_chg  = dip_flip != flip_prev;
    assign dl_fall   = dl_prev && !downloading;
    assign rst_cause = rst_req || downloading || soft_rst || flip_chg || dl_fall;

    // Any cause reloads the hold counter
    always_ff @(posedge clk_sys or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            hold_cnt  <= RST_CNT_W'(RST_HOLD);
            flip_prev <= 1'b0;
            dl_prev   <= 1'b0;
        end else begin
            flip_prev <= dip_flip;
            dl_prev   <= downloading;
            if (rst_cause) begin
                hold_cnt <= RST_CNT_W'(RST_HOLD);
            end else if (hold_cnt != '0) begin
                hold_cnt <= hold_cnt - 1'b1;
            end
        end
    end

    // Level causes pull game reset low right away
    assign game_rst_n = (hold_cnt == '0) && !rst_req && !downloading;

    // Game stays in reset through download and for the hold time after it
    a_dl_holds_reset: assert property (
        @(posedge clk_sys) disable iff (!sys_rst_n)
        downloading |-> !game_rst_n ##RST_HOLD !game_rst_n
    );

endmodule

/* inputs/input_capture.sv */
module input_capture
    import board_pkg::*;
(
    input  logic       clk_sys,
    input  logic       sys_rst_n,
    input  logic       downloading,
    input  board_joy_t board_joy [PLAYERS],
    output board_joy_t raw       [PLAYERS]
);

    // Board joysticks are active high, so zero means nothing pressed
    always_ff @(posedge clk_sys or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            for (int i = 0; i < PLAYERS; i++) begin
                raw[i] <= '0;
            end
        end else begin
            for (int i = 0; i < PLAYERS; i++) begin
                // No presses reach the game while ROMs load
                raw[i] <= downloading ? '0 : board_joy[i];
            end
        end
    end

endmodule

/* inputs/player_channel.sv */
module player_channel
    import board_pkg::*;
(
    input  logic       clk_sys,
    input  logic       sys_rst_n,
    input  logic       rot_control,
    input  board_joy_t raw,
    player_if.channel  ctl
);

    game_joy_t             joy_rot;
    logic                  coin_prev;
    logic                  coin_edge;
    logic                  coin_act;
    logic [COIN_CNT_W-1:0] coin_cnt;

    // Rotated cabinets turn the stick a quarter turn
    always_comb begin
        joy_rot = raw[GAME_JOY_W-1:0];
        if (rot_control) begin
            joy_rot[JOY_RIGHT] = raw[JOY_UP];
            joy_rot[JOY_LEFT]  = raw[JOY_DOWN];
            joy_rot[JOY_DOWN]  = raw[JOY_RIGHT];
            joy_rot[JOY_UP]    = raw[JOY_LEFT];
        end
    end

    assign coin_edge = raw[JOY_COIN] && !coin_prev;

    // Fixed length coin pulse, new edges ignored while one is running
    always_ff @(posedge clk_sys or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            coin_prev <= 1'b0;
            coin_act  <= 1'b0;
            coin_cnt  <= '0;
        end else begin
            coin_prev <= raw[JOY_COIN];
            if (coin_edge && !coin_act) begin
                coin_act <= 1'b1;
                coin_cnt <= COIN_CNT_W'(COIN_CYCLES - 1);
            end else if (coin_cnt != '0) begin
                coin_cnt <= coin_cnt - 1'b1;
            end else begin
                coin_act <= 1'b0;
            end
        end
    end

    assign ctl.coin = coin_act ^ GAME_INPUTS_ACTIVE_LOW;

    always_ff @(posedge clk_sys or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            ctl.joy     <= {GAME_JOY_W{GAME_INPUTS_ACTIVE_LOW}};
            ctl.start   <= GAME_INPUTS_ACTIVE_LOW;
            ctl.service <= GAME_INPUTS_ACTIVE_LOW;
        end else begin
            ctl.joy     <= joy_rot ^ {GAME_JOY_W{GAME_INPUTS_ACTIVE_LOW}};
            ctl.start   <= raw[JOY_START] ^ GAME_INPUTS_ACTIVE_LOW;
            ctl.service <= raw[JOY_SERVICE] ^ GAME_INPUTS_ACTIVE_LOW;
        end
    end

    a_coin_len: assert property (
        @(posedge clk_sys) disable iff (!sys_rst_n)
        $rose(coin_act) |-> ##COIN_CYCLES !coin_act
    );

endmodule

/* inputs/input_collect.sv */
module input_collect
    import board_pkg::*;
(
    input  logic               clk_sys,
    input  logic               sys_rst_n,
    input  logic               pause_key,
    input  logic               reset_key,
    player_if.collect          ctl [PLAYERS],
    output game_joy_t          game_joy [PLAYERS],
    output logic [PLAYERS-1:0] game_coin,
    output logic [PLAYERS-1:0] game_start,
    output logic               game_service,
    output logic               game_pause,
    output logic               soft_rst
);

    logic [PLAYERS-1:0] coin_in;
    logic [PLAYERS-1:0] start_in;
    logic [PLAYERS-1:0] svc_act;
    logic               pause_prev;
    logic               reset_prev;

    for (genvar i = 0; i < PLAYERS; i++) begin : g_player
        assign coin_in[i]  = ctl[i].coin;
        assign start_in[i] = ctl[i].start;
        // Service as active high so the players can be OR-ed
        assign svc_act[i]  = ctl[i].service ^ GAME_INPUTS_ACTIVE_LOW;

        always_ff @(posedge clk_sys or negedge sys_rst_n) begin
            if (!sys_rst_n) begin
                game_joy[i] <= {GAME_JOY_W{GAME_INPUTS_ACTIVE_LOW}};
            end else begin
                game_joy[i] <= ctl[i].joy;
            end
        end
    end

    always_ff @(posedge clk_sys or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            game_coin    <= {PLAYERS{GAME_INPUTS_ACTIVE_LOW}};
            game_start   <= {PLAYERS{GAME_INPUTS_ACTIVE_LOW}};
            game_service <= GAME_INPUTS_ACTIVE_LOW;
            pause_prev   <= 1'b0;
            reset_prev   <= 1'b0;
            game_pause   <= 1'b0;
            soft_rst     <= 1'b0;
        end else begin
            game_coin    <= coin_in;
            game_start   <= start_in;
            game_service <= (|svc_act) ^ GAME_INPUTS_ACTIVE_LOW;
            pause_prev   <= pause_key;
            reset_prev   <= reset_key;
            // Each press flips pause
            if (pause_key && !pause_prev) begin
                game_pause <= ~game_pause;
            end
            soft_rst <= reset_key && !reset_prev;
        end
    end

    a_soft_rst_pulse: assert property (
        @(posedge clk_sys) disable iff (!sys_rst_n)
        soft_rst |=> !soft_rst
    );

endmodule

/* logic/dip_decode.sv */
module dip_decode
    import board_pkg::*;
(
    input  logic                  clk_sys,
    input  logic                  sys_rst_n,
    input  status_t               status,
    input  logic [CORE_MOD_W-1:0] core_mod,
    input  logic                  game_pause,
    output logic [1:0]            rotate,
    output logic                  rot_control,
    output logic                  dip_test,
    output logic                  dip_pause,
    output logic                  dip_flip,
    output fx_t                   dip_fxlevel,
    output logic                  enable_fm,
    output logic                  enable_psg,
    output aspect_t               hdmi_arx,
    output aspect_t               hdmi_ary
);

    logic vertical;
    logic swap_ar;

    assign vertical = core_mod[CM_VERTICAL];
    // Vertical game shown unrotated needs a tall frame
    assign swap_ar  = vertical && !status[ST_ROTATE];

    always_ff @(posedge clk_sys or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            rotate      <= '0;
            rot_control <= 1'b0;
            dip_test    <= 1'b0;
            dip_pause   <= 1'b1;
            dip_flip    <= 1'b0;
            dip_fxlevel <= '0;
            enable_fm   <= 1'b1;
            enable_psg  <= 1'b1;
            hdmi_arx    <= ASPECT_H_X;
            hdmi_ary    <= ASPECT_H_Y;
        end else begin
            rotate[0]   <= status[ST_ROTATE] && vertical;
            rotate[1]   <= status[ST_FLIP];
            rot_control <= status[ST_ROT_CTRL];
            dip_test    <= status[ST_TEST];
            // Active low, either source pauses the game
            dip_pause   <= !(game_pause || status[ST_PAUSE]);
            dip_flip    <= status[ST_FLIP];
            dip_fxlevel <= status[ST_FX +: FX_W];
            enable_fm   <= !status[ST_NO_FM];
            enable_psg  <= !status[ST_NO_PSG];
            hdmi_arx    <= swap_ar ? ASPECT_H_Y : ASPECT_H_X;
            hdmi_ary    <= swap_ar ? ASPECT_H_X : ASPECT_H_Y;
        end
    end

endmodule

/* logic/board_led.sv */
module board_led
    import board_pkg::*;
(
    input  logic                  clk_sys,
    input  logic                  sys_rst_n,
    input  logic                  downloading,
    input  logic                  osd_shown,
    input  logic [GAME_LED_W-1:0] game_led,
    output logic                  led
);

    led_state_t             state;
    led_state_t             state_nxt;
    logic [LED_BLINK_W-1:0] blink_cnt;
    logic                   blink_q;

    // Download wins over the OSD, the OSD over the game
    always_comb begin
        if (downloading) begin
            state_nxt = LED_BLINK;
        end else if (osd_shown) begin
            state_nxt = LED_OSD;
        end else begin
            state_nxt = LED_GAME;
        end
    end

    always_ff @(posedge clk_sys or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state     <= LED_GAME;
            blink_cnt <= '0;
            blink_q   <= 1'b0;
            led       <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state != LED_BLINK) begin
                // Start blinking from the opposite of what is lit now
                blink_cnt <= '0;
                blink_q   <= ~led;
            end else begin
                blink_cnt <= blink_cnt + 1'b1;
                if (&blink_cnt) begin
                    blink_q <= ~blink_q;
                end
            end
            case (state_nxt)
                LED_BLINK: led <= blink_q;
                LED_OSD:   led <= 1'b1;
                default:   led <= game_led[0];
            endcase
        end
    end

endmodule

/* logic/board_top.sv */
module board_top
    import board_pkg::*;
(
    input  logic                  clk_sys,
    input  logic                  rst_n,
    input  logic                  pll_locked,
    input  logic                  rst_req,
    input  logic                  downloading,
    input  logic                  osd_shown,
    input  logic                  pause_key,
    input  logic                  reset_key,
    input  logic [GAME_LED_W-1:0] game_led,
    input  logic [CORE_MOD_W-1:0] core_mod,
    input  status_t               status,
    input  board_joy_t            board_joystick1,
    input  board_joy_t            board_joystick2,
    input  board_joy_t            board_joystick3,
    input  board_joy_t            board_joystick4,
    output logic                  game_rst_n,
    output logic                  led,
    output logic                  game_service,
    output logic                  dip_test,
    output logic                  dip_pause,
    output logic                  dip_flip,
    output logic                  enable_fm,
    output logic                  enable_psg,
    output game_joy_t             game_joystick1,
    output game_joy_t             game_joystick2,
    output game_joy_t             game_joystick3,
    output game_joy_t             game_joystick4,
    output logic [PLAYERS-1:0]    game_coin,
    output logic [PLAYERS-1:0]    game_start,
    output logic [1:0]            rotate,
    output fx_t                   dip_fxlevel,
    output aspect_t               hdmi_arx,
    output aspect_t               hdmi_ary
);

    logic       sys_rst_n;
    logic       soft_rst;
    logic       game_pause;
    logic       rot_control;
    board_joy_t board_joy [PLAYERS];
    board_joy_t raw       [PLAYERS];
    game_joy_t  game_joy  [PLAYERS];

    player_if ctl [PLAYERS] ();

    assign board_joy[0] = board_joystick1;
    assign board_joy[1] = board_joystick2;
    assign board_joy[2] = board_joystick3;
    assign board_joy[3] = board_joystick4;

    assign game_joystick1 = game_joy[0];
    assign game_joystick2 = game_joy[1];
    assign game_joystick3 = game_joy[2];
    assign game_joystick4 = game_joy[3];

    board_reset u_reset (
        .clk_sys     ( clk_sys     ),
        .rst_n       ( rst_n       ),
        .pll_locked  ( pll_locked  ),
        .rst_req     ( rst_req     ),
        .downloading ( downloading ),
        .soft_rst    ( soft_rst    ),
        .dip_flip    ( dip_flip    ),
        .sys_rst_n   ( sys_rst_n   ),
        .game_rst_n  ( game_rst_n  )
    );

    input_capture u_capture (
        .clk_sys     ( clk_sys     ),
        .sys_rst_n   ( sys_rst_n   ),
        .downloading ( downloading ),
        .board_joy   ( board_joy   ),
        .raw         ( raw         )
    );

    for (genvar i = 0; i < PLAYERS; i++) begin : g_channel
        player_channel u_channel (
            .clk_sys     ( clk_sys     ),
            .sys_rst_n   ( sys_rst_n   ),
            .rot_control ( rot_control ),
            .raw         ( raw[i]      ),
            .ctl         ( ctl[i]      )
        );
    end

    input_collect u_collect (
        .clk_sys      ( clk_sys      ),
        .sys_rst_n    ( sys_rst_n    ),
        .pause_key    ( pause_key    ),
        .reset_key    ( reset_key    ),
        .ctl          ( ctl          ),
        .game_joy     ( game_joy     ),
        .game_coin    ( game_coin    ),
        .game_start   ( game_start   ),
        .game_service ( game_service ),
        .game_pause   ( game_pause   ),
        .soft_rst     ( soft_rst     )
    );

    dip_decode u_dip (
        .clk_sys     ( clk_sys     ),
        .sys_rst_n   ( sys_rst_n   ),
        .status      ( status      ),
        .core_mod    ( core_mod    ),
        .game_pause  ( game_pause  ),
        .rotate      ( rotate      ),
        .rot_control ( rot_control ),
        .dip_test    ( dip_test    ),
        .dip_pause   ( dip_pause   ),
        .dip_flip    ( dip_flip    ),
        .dip_fxlevel ( dip_fxlevel ),
        .enable_fm   ( enable_fm   ),
        .enable_psg  ( enable_psg  ),
        .hdmi_arx    ( hdmi_arx    ),
        .hdmi_ary    ( hdmi_ary    )
    );

    board_led u_led (
        .clk_sys     ( clk_sys     ),
        .sys_rst_n   ( sys_rst_n   ),
        .downloading ( downloading ),
        .osd_shown   ( osd_shown   ),
        .game_led    ( game_led    ),
        .led         ( led         )
    );

endmodule

/* bench/board_tb.sv */
module board_tb
    import board_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT    = 100;
    localparam int SEL_GAME_RST  = 0;
    localparam int SEL_DIP_PAUSE = 1;

    logic                  clk_sys;
    logic                  rst_n;
    logic                  pll_locked;
    logic                  rst_req;
    logic                  downloading;
    logic                  osd_shown;
    logic                  pause_key;
    logic                  reset_key;
    logic [GAME_LED_W-1:0] game_led;
    logic [CORE_MOD_W-1:0] core_mod;
    status_t               status;
    board_joy_t            board_joy [PLAYERS];
    logic                  game_rst_n;
    logic                  led;
    logic                  game_service;
    logic                  dip_test;
    logic                  dip_pause;
    logic                  dip_flip;
    logic                  enable_fm;
    logic                  enable_psg;
    game_joy_t             game_joy [PLAYERS];
    logic [PLAYERS-1:0]    game_coin;
    logic [PLAYERS-1:0]    game_start;
    logic [1:0]            rotate;
    fx_t                   dip_fxlevel;
    aspect_t               hdmi_arx;
    aspect_t               hdmi_ary;

    logic [31:0] lfsr;
    int          errors;
    int          tests;
    int          test_err_start;
    string       test_name;

    board_top dut0 (
        .clk_sys         ( clk_sys      ),
        .rst_n           ( rst_n        ),
        .pll_locked      ( pll_locked   ),
        .rst_req         ( rst_req      ),
        .downloading     ( downloading  ),
        .osd_shown       ( osd_shown    ),
        .pause_key       ( pause_key    ),
        .reset_key       ( reset_key    ),
        .game_led        ( game_led     ),
        .core_mod        ( core_mod     ),
        .status          ( status       ),
        .board_joystick1 ( board_joy[0] ),
        .board_joystick2 ( board_joy[1] ),
        .board_joystick3 ( board_joy[2] ),
        .board_joystick4 ( board_joy[3] ),
        .game_rst_n      ( game_rst_n   ),
        .led             ( led          ),
        .game_service    ( game_service ),
        .dip_test        ( dip_test     ),
        .dip_pause       ( dip_pause    ),
        .dip_flip        ( dip_flip     ),
        .enable_fm       ( enable_fm    ),
        .enable_psg      ( enable_psg   ),
        .game_joystick1  ( game_joy[0]  ),
        .game_joystick2  ( game_joy[1]  ),
        .game_joystick3  ( game_joy[2]  ),
        .game_joystick4  ( game_joy[3]  ),
        .game_coin       ( game_coin    ),
        .game_start      ( game_start   ),
        .rotate          ( rotate       ),
        .dip_fxlevel     ( dip_fxlevel  ),
        .hdmi_arx        ( hdmi_arx     ),
        .hdmi_ary        ( hdmi_ary     )
    );

    initial begin
        clk_sys = 1'b0;
        forever #50 clk_sys = ~clk_sys;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr_bit();
        end
        return v;
    endfunction

    task automatic check_joy(input string what, input game_joy_t exp, input game_joy_t act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %h actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %b actual %b", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_aspect(input string what, input aspect_t exp, input aspect_t act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %h actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_coin(input string what, input logic [PLAYERS-1:0] exp,
                              input logic [PLAYERS-1:0] act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %b actual %b", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (act != exp) begin
            $display("ERR %s %s: expected %0d actual %0d", test_name, what, exp, act);
            errors++;
        end
    endtask

    function automatic logic sample(input int sel);
        if (sel == SEL_GAME_RST) begin
            return game_rst_n;
        end
        return dip_pause;
    endfunction

    // Polls on the falling edge, where outputs are settled
    task automatic wait_for(input int sel, input logic val, input int limit, input string what);
        int cnt;
        cnt = 0;
        do begin
            @(negedge clk_sys);
            cnt++;
        end while (sample(sel) !== val && cnt < limit);
        if (sample(sel) !== val) begin
            $display("%s: timed out after %0d cycles waiting for %s", test_name, limit, what);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name      = name;
        test_err_start = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("%s finished with %0d errors", test_name, errors - test_err_start);
    endtask

    // Expected game direction for a board direction in a rotated cabinet
    function automatic int rotated_dir(input int d);
        case (d)
            JOY_UP:    return JOY_RIGHT;
            JOY_DOWN:  return JOY_LEFT;
            JOY_RIGHT: return JOY_DOWN;
            default:   return JOY_UP;
        endcase
    endfunction

    task automatic pulse_key(input int which);
        @(posedge clk_sys);
        if (which == 0) pause_key <= 1'b1;
        else reset_key <= 1'b1;
        @(posedge clk_sys);
        pause_key <= 1'b0;
        reset_key <= 1'b0;
    endtask

    task automatic test_reset();
        int low_cycles;
        begin_test("reset sequence");
        wait_for(SEL_GAME_RST, 1'b1, WAIT_LIMIT, "first game reset release");
        @(posedge clk_sys);
        downloading <= 1'b1;
        repeat (10) begin
            @(negedge clk_sys);
            check_bit("game_rst_n in download", 1'b0, game_rst_n);
        end
        @(posedge clk_sys);
        downloading <= 1'b0;
        low_cycles = 0;
        @(negedge clk_sys);
        while (game_rst_n === 1'b0 && low_cycles < WAIT_LIMIT) begin
            low_cycles++;
            @(negedge clk_sys);
        end
        if (game_rst_n !== 1'b1) begin
            $display("%s: game reset never released after download", test_name);
            errors++;
        end else if (low_cycles < RST_HOLD) begin
            $display("ERR %s hold after download: expected at least %0d actual %0d",
                     test_name, RST_HOLD, low_cycles);
            errors++;
        end
        end_test();
    endtask

    task automatic test_joystick();
        board_joy_t v [PLAYERS];
        logic       svc;
        begin_test("joystick mapping");
        for (int n = 0; n < 20; n++) begin
            @(posedge clk_sys);
            for (int p = 0; p < PLAYERS; p++) begin
                v[p] = board_joy_t'(rand_bits(BOARD_JOY_W));
                v[p][JOY_COIN] = 1'b0;
                board_joy[p] <= v[p];
            end
            repeat (3) @(posedge clk_sys);
            @(negedge clk_sys);
            svc = 1'b0;
            for (int p = 0; p < PLAYERS; p++) begin
                check_joy($sformatf("joystick %0d", p + 1), ~v[p][GAME_JOY_W-1:0], game_joy[p]);
                check_bit($sformatf("start %0d", p + 1), ~v[p][JOY_START], game_start[p]);
                svc = svc | v[p][JOY_SERVICE];
            end
            check_bit("service", ~svc, game_service);
        end
        end_test();
    endtask

    task automatic test_rotation();
        board_joy_t v;
        game_joy_t  pressed;
        logic [5:0] btn;
        begin_test("rotated controls");
        @(posedge clk_sys);
        status <= '0;
        status[ST_ROT_CTRL] <= 1'b1;
        for (int d = 0; d < 4; d++) begin
            btn = 6'(rand_bits(6));
            v = '0;
            v[d] = 1'b1;
            v[JOY_BTN +: 6] = btn;
            pressed = '0;
            pressed[rotated_dir(d)] = 1'b1;
            pressed[JOY_BTN +: 6] = btn;
            @(posedge clk_sys);
            for (int p = 0; p < PLAYERS; p++) begin
                board_joy[p] <= v;
            end
            repeat (3) @(posedge clk_sys);
            @(negedge clk_sys);
            for (int p = 0; p < PLAYERS; p++) begin
                check_joy($sformatf("dir %0d player %0d", d, p + 1), ~pressed, game_joy[p]);
            end
        end
        @(posedge clk_sys);
        status <= '0;
        for (int p = 0; p < PLAYERS; p++) begin
            board_joy[p] <= '0;
        end
        end_test();
    endtask

    task automatic test_coin();
        int                 low_cycles;
        logic [PLAYERS-1:0] exp_low;
        begin_test("coin pulse");
        for (int p = 0; p < PLAYERS; p++) begin
            exp_low    = '1;
            exp_low[p] = 1'b0;
            low_cycles = 0;
            @(posedge clk_sys);
            board_joy[p] <= board_joy_t'(1) << JOY_COIN;
            repeat (40) begin
                @(negedge clk_sys);
                if (game_coin === exp_low) begin
                    low_cycles++;
                end else begin
                    check_coin($sformatf("idle coins player %0d", p + 1), '1, game_coin);
                end
            end
            @(posedge clk_sys);
            board_joy[p] <= '0;
            check_count($sformatf("coin cycles player %0d", p + 1), COIN_CYCLES, low_cycles);
        end
        end_test();
    endtask

    task automatic test_settings();
        logic  vert;
        logic  swap;
        string tag;
        begin_test("settings decode");
        for (int m = 0; m < 2; m++) begin
            for (int b = 0; b < 10; b++) begin
                vert = (m == 1);
                swap = vert && (b != ST_ROTATE);
                tag  = $sformatf(" bit %0d vertical %0d", b, m);
                // Start the flip step from a running game
                if (b == ST_FLIP) begin
                    wait_for(SEL_GAME_RST, 1'b1, WAIT_LIMIT, "release before flip");
                end
                @(posedge clk_sys);
                status <= status_t'(1) << b;
                core_mod <= '0;
                core_mod[CM_VERTICAL] <= vert;
                @(posedge clk_sys);
                @(negedge clk_sys);
                check_bit({"rotate0", tag}, (b == ST_ROTATE) && vert, rotate[0]);
                check_bit({"rotate1", tag}, b == ST_FLIP, rotate[1]);
                check_bit({"dip_test", tag}, b == ST_TEST, dip_test);
                check_bit({"dip_flip", tag}, b == ST_FLIP, dip_flip);
                check_bit({"dip_pause", tag}, b != ST_PAUSE, dip_pause);
                check_bit({"fx0", tag}, b == ST_FX, dip_fxlevel[0]);
                check_bit({"fx1", tag}, b == ST_FX + 1, dip_fxlevel[1]);
                check_bit({"enable_fm", tag}, b != ST_NO_FM, enable_fm);
                check_bit({"enable_psg", tag}, b != ST_NO_PSG, enable_psg);
                check_aspect({"hdmi_arx", tag}, swap ? ASPECT_H_Y : ASPECT_H_X, hdmi_arx);
                check_aspect({"hdmi_ary", tag}, swap ? ASPECT_H_X : ASPECT_H_Y, hdmi_ary);
                if (b == ST_FLIP) begin
                    wait_for(SEL_GAME_RST, 1'b0, 5, "game reset on flip");
                    wait_for(SEL_GAME_RST, 1'b1, WAIT_LIMIT, "release after flip");
                end
            end
        end
        @(posedge clk_sys);
        status   <= '0;
        core_mod <= '0;
        wait_for(SEL_GAME_RST, 1'b1, WAIT_LIMIT, "release after settings walk");
        end_test();
    endtask

    task automatic test_pause_led();
        logic led_start;
        int   cnt;
        begin_test("pause, soft reset and led");
        pulse_key(0);
        wait_for(SEL_DIP_PAUSE, 1'b0, 5, "pause on");
        pulse_key(0);
        wait_for(SEL_DIP_PAUSE, 1'b1, 5, "pause off");
        pulse_key(1);
        wait_for(SEL_GAME_RST, 1'b0, 5, "soft reset");
        wait_for(SEL_GAME_RST, 1'b1, WAIT_LIMIT, "release after soft reset");
        @(posedge clk_sys);
        osd_shown <= 1'b1;
        game_led  <= 2'b00;
        @(posedge clk_sys);
        @(negedge clk_sys);
        check_bit("led with osd", 1'b1, led);
        @(posedge clk_sys);
        osd_shown <= 1'b0;
        @(posedge clk_sys);
        @(negedge clk_sys);
        check_bit("led game off", 1'b0, led);
        @(posedge clk_sys);
        game_led <= 2'b01;
        @(posedge clk_sys);
        @(negedge clk_sys);
        check_bit("led game on", 1'b1, led);
        @(posedge clk_sys);
        game_led <= 2'b10;
        @(posedge clk_sys);
        @(negedge clk_sys);
        check_bit("led ignores bit 1", 1'b0, led);
        @(posedge clk_sys);
        downloading <= 1'b1;
        @(negedge clk_sys);
        // Two changes, the second one from the blink counter
        for (int k = 0; k < 2; k++) begin
            led_start = led;
            cnt = 0;
            do begin
                @(negedge clk_sys);
                cnt++;
            end while (led === led_start && cnt < 40);
            if (led === led_start) begin
                $display("%s: led did not change within 40 cycles of download", test_name);
                errors++;
            end
        end
        @(posedge clk_sys);
        downloading <= 1'b0;
        wait_for(SEL_GAME_RST, 1'b1, WAIT_LIMIT, "release after download");
        end_test();
    endtask

    initial begin
        rst_n       = 1'b0;
        pll_locked  = 1'b1;
        rst_req     = 1'b0;
        downloading = 1'b0;
        osd_shown   = 1'b0;
        pause_key   = 1'b0;
        reset_key   = 1'b0;
        game_led    = '0;
        core_mod    = '0;
        status      = '0;
        for (int p = 0; p < PLAYERS; p++) begin
            board_joy[p] = '0;
        end
        lfsr   = 32'hd671;
        errors = 0;
        tests  = 0;
        repeat (5) @(posedge clk_sys);
        rst_n <= 1'b1;

        test_reset();
        test_joystick();
        test_rotation();
        test_coin();
        test_settings();
        test_pause_led();

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* src.f */
common/board_pkg.sv
common/player_if.sv
reset/board_reset.sv
inputs/input_capture.sv
inputs/player_channel.sv
inputs/input_collect.sv
logic/dip_decode.sv
logic/board_led.sv
logic/board_top.sv
bench/board_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module board_tb -f src.f -o board_sim

out=$(./obj_dir/board_sim)
echo "$out"

if echo "$out" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1
